// ==== hw/qc_pkg.sv ====
package qc_pkg;

    ////////////////////////////////////////////////////////////////////
    // Data path widths
    ////////////////////////////////////////////////////////////////////

    // Signal sample width, also used for the gain word
    localparam int SAMPLE_W = 16;

    // Delay in samples, sets the ring depth
    localparam int DELAY_W = 13;

    // Ring memory entries
    localparam int DEPTH = 8192;

    ////////////////////////////////////////////////////////////////////
    // Gain format and output limits
    ////////////////////////////////////////////////////////////////////

    // Gain is Q13, 8192 is unity
    localparam int GAIN_Q = 13;

    // Clamp range of the rescaled product
    localparam int SAT_MAX = 32767;
    localparam int SAT_MIN = -32768;

    ////////////////////////////////////////////////////////////////////
    // Sample rate
    ////////////////////////////////////////////////////////////////////

    // Clock cycles per input sample
    localparam int DECIM = 4;

    // Signed input and delayed samples
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Signed gain, Q13
    typedef logic signed [SAMPLE_W-1:0] gain_t;

    // Delay count, zero means full ring depth
    typedef logic [DELAY_W-1:0] delay_t;

    // Full width sample times gain
    typedef logic signed [2*SAMPLE_W-1:0] product_t;

    // Capture sequencer
    // CAP_IDLE until the first tick, then CAP_RUN for good
    typedef enum logic [0:0] {
        CAP_IDLE,
        CAP_RUN
    } cap_state_t;

endpackage

// ==== hw/qc_sample_capture.sv ====
`timescale 1ns/1ns

module qc_sample_capture (
    input  logic            a_clk,
    input  logic            rst,
    input  qc_pkg::sample_t signal_data,
    input  logic            qc_enable,
    input  qc_pkg::gain_t   qc_gain,
    input  qc_pkg::delay_t  qc_delay,
    output logic            sample_en,
    output qc_pkg::sample_t cap_sample,
    output logic            cap_enable,
    output qc_pkg::gain_t   cap_gain,
    output qc_pkg::delay_t  cap_delay
);
    import qc_pkg::*;

    // Decimation counter, runs 0 to DECIM-1
    logic [$clog2(DECIM)-1:0] dec_cnt;
    logic                     tick;

    // Sequencer state
    cap_state_t state;

    // Enable as latched, before the startup mask
    logic en_q;

    ////////////////////////////////////////////////////////////////////
    // Tick generation and sequencer
    ////////////////////////////////////////////////////////////////////

    // Last count of a period
    assign tick = (dec_cnt == DECIM - 1);

    always_ff @(posedge a_clk)
    begin
        if (rst)
        begin
            dec_cnt   <= '0;
            sample_en <= 1'b0;
            state     <= CAP_IDLE;
        end
        else
        begin
            // Strobe trails the tick by one cycle
            sample_en <= tick;

            // Wrap at the tick
            if (tick)
            begin
                dec_cnt <= '0;
            end
            else
            begin
                dec_cnt <= dec_cnt + 1'b1;
            end

            case (state)
                CAP_IDLE:
                begin
                    // First capture opens the output
                    if (tick)
                    begin
                        state <= CAP_RUN;
                    end
                end
                CAP_RUN:
                begin
                    state <= CAP_RUN;
                end
                default:
                begin
                    state <= CAP_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Sample and settings latch
    ////////////////////////////////////////////////////////////////////

    // One consistent set of settings per sample
    // Held until the next tick
    always_ff @(posedge a_clk)
    begin
        if (tick)
        begin
            cap_sample <= signal_data;
            cap_gain   <= qc_gain;
            cap_delay  <= qc_delay;
            en_q       <= qc_enable;
        end
    end

    // Nothing captured yet in CAP_IDLE, keep the mixer off
    assign cap_enable = (state == CAP_RUN) && en_q;

endmodule

// ==== hw/qc_delay_line.sv ====
`timescale 1ns/1ns

module qc_delay_line (
    input  logic            a_clk,
    input  logic            rst,
    input  logic            sample_en,
    input  qc_pkg::sample_t cap_sample,
    input  qc_pkg::delay_t  cap_delay,
    output logic            dly_valid,
    output qc_pkg::sample_t dly_sample
);
    import qc_pkg::*;

    // Ring storage
    sample_t mem [DEPTH];

    // Write pointer wraps modulo DEPTH by its width
    delay_t wr_ptr;
    delay_t rd_addr;

    // Samples written since reset, saturates at DEPTH
    logic [DELAY_W:0] fill_cnt;

    // History needed for the requested delay
    logic [DELAY_W:0] need;

    // Raw read and its mask
    sample_t rd_q;
    logic    rd_mask;

    ////////////////////////////////////////////////////////////////////
    // Address and fill check
    ////////////////////////////////////////////////////////////////////

    // Entry written D samples back
    // D of zero lands on the slot about to be overwritten
    assign rd_addr = wr_ptr - cap_delay;

    // Zero delay means a full ring of history
    assign need = (cap_delay == '0) ? (DELAY_W + 1)'(DEPTH) : {1'b0, cap_delay};

    ////////////////////////////////////////////////////////////////////
    // Memory
    ////////////////////////////////////////////////////////////////////

    // Read before write in the same edge
    always_ff @(posedge a_clk)
    begin
        if (sample_en)
        begin
            rd_q        <= mem[rd_addr];
            mem[wr_ptr] <= cap_sample;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Pointer, fill count and valid
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (rst)
        begin
            wr_ptr    <= '0;
            fill_cnt  <= '0;
            rd_mask   <= 1'b1;
            dly_valid <= 1'b0;
        end
        else
        begin
            // One read result per strobe
            dly_valid <= sample_en;

            if (sample_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;

                // Stop counting once the ring is full
                if (fill_cnt != (DELAY_W + 1)'(DEPTH))
                begin
                    fill_cnt <= fill_cnt + 1'b1;
                end

                // Slot not written yet since reset
                rd_mask <= (fill_cnt < need);
            end
        end
    end

    // Unwritten slots read as zero
    assign dly_sample = rd_mask ? '0 : rd_q;

endmodule

// ==== hw/qc_gain_mixer.sv ====
`timescale 1ns/1ns

module qc_gain_mixer (
    input  logic            a_clk,
    input  logic            rst,
    input  logic            dly_valid,
    input  qc_pkg::sample_t dly_sample,
    input  logic            cap_enable,
    input  qc_pkg::gain_t   cap_gain,
    output qc_pkg::sample_t qc_data,
    output logic            qc_valid
);
    import qc_pkg::*;

    // Full product and its rescaled form
    product_t product;
    product_t scaled;

    // Clamped to the sample range
    sample_t sat_val;

    // Result register and the enable that goes with it
    sample_t sat_q;
    logic    en_q;

    ////////////////////////////////////////////////////////////////////
    // Multiply and rescale
    ////////////////////////////////////////////////////////////////////

    // Signed 16 x 16 into 32
    assign product = dly_sample * cap_gain;

    // Drop the Q13 fraction, sign kept
    assign scaled = product >>> GAIN_Q;

    ////////////////////////////////////////////////////////////////////
    // Saturation
    ////////////////////////////////////////////////////////////////////

    always_comb
    begin
        if (scaled > SAT_MAX)
        begin
            sat_val = sample_t'(SAT_MAX);
        end
        else if (scaled < SAT_MIN)
        begin
            sat_val = sample_t'(SAT_MIN);
        end
        else
        begin
            // In range, low half is exact
            sat_val = sample_t'(scaled);
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////////////////////////////////

    // Gain and enable from the sample's tick are still held here
    // Next tick is DECIM cycles away
    always_ff @(posedge a_clk)
    begin
        if (dly_valid)
        begin
            sat_q <= sat_val;
        end
    end

    always_ff @(posedge a_clk)
    begin
        if (rst)
        begin
            en_q     <= 1'b0;
            qc_valid <= 1'b0;
        end
        else
        begin
            // Single cycle pulse per sample
            qc_valid <= dly_valid;

            // Enable realigned with the result
            if (dly_valid)
            begin
                en_q <= cap_enable;
            end
        end
    end

    // Disabled samples come out as zero
    assign qc_data = en_q ? sat_q : '0;

endmodule

// ==== hw/q_control.sv ====
`timescale 1ns/1ns

module q_control (
    input  logic            a_clk,
    input  logic            rst,
    input  qc_pkg::sample_t signal_data,
    input  logic            qc_enable,
    input  qc_pkg::gain_t   qc_gain,
    input  qc_pkg::delay_t  qc_delay,
    output qc_pkg::sample_t qc_data,
    output logic            qc_valid
);
    import qc_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // Capture outputs
    ////////////////////////////////////////////////////////////////////

    // Strobe, one per DECIM cycles
    logic    sample_en;

    // Sample and settings held between strobes
    sample_t cap_sample;
    logic    cap_enable;
    gain_t   cap_gain;
    delay_t  cap_delay;

    ////////////////////////////////////////////////////////////////////
    // Delay line outputs
    ////////////////////////////////////////////////////////////////////

    logic    dly_valid;
    sample_t dly_sample;

    // Decimation and settings latch
    qc_sample_capture cap0 (
        .a_clk       (a_clk),
        .rst         (rst),
        .signal_data (signal_data),
        .qc_enable   (qc_enable),
        .qc_gain     (qc_gain),
        .qc_delay    (qc_delay),
        .sample_en   (sample_en),
        .cap_sample  (cap_sample),
        .cap_enable  (cap_enable),
        .cap_gain    (cap_gain),
        .cap_delay   (cap_delay)
    );

    // Ring delay with fill masking
    qc_delay_line dly0 (
        .a_clk      (a_clk),
        .rst        (rst),
        .sample_en  (sample_en),
        .cap_sample (cap_sample),
        .cap_delay  (cap_delay),
        .dly_valid  (dly_valid),
        .dly_sample (dly_sample)
    );

    // Gain, rescale and clamp
    qc_gain_mixer mix0 (
        .a_clk      (a_clk),
        .rst        (rst),
        .dly_valid  (dly_valid),
        .dly_sample (dly_sample),
        .cap_enable (cap_enable),
        .cap_gain   (cap_gain),
        .qc_data    (qc_data),
        .qc_valid   (qc_valid)
    );

endmodule

// ==== tb/q_control_chk.sv ====
`timescale 1ns/1ns

module q_control_chk (
    input logic            a_clk,
    input logic            rst,
    input logic            sample_en,
    input logic            dly_valid,
    input logic            cap_enable,
    input logic            qc_valid,
    input qc_pkg::sample_t qc_data
);
    import qc_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // Cadence
    ////////////////////////////////////////////////////////////////////

    // Strobe at most once per DECIM cycles
    a_strobe_gap: assert property (@(posedge a_clk) disable iff (rst)
        sample_en |-> ##1 !sample_en ##1 !sample_en ##1 !sample_en)
        else $error("sample_en repeated within %0d cycles", DECIM);

    // Output pulse never recurs inside a sample period
    a_valid_gap: assert property (@(posedge a_clk) disable iff (rst)
        qc_valid |-> ##1 !qc_valid ##1 !qc_valid ##1 !qc_valid)
        else $error("qc_valid repeated within %0d cycles", DECIM);

    ////////////////////////////////////////////////////////////////////
    // Reset and gating
    ////////////////////////////////////////////////////////////////////

    // Quiet outputs right after a reset edge
    a_reset_state: assert property (@(posedge a_clk)
        rst |=> (!qc_valid && !sample_en && qc_data == '0))
        else $error("outputs not cleared by reset");

    // Enable off at the sample's tick, zero pulse one cycle later
    a_gate_zero: assert property (@(posedge a_clk) disable iff (rst)
        (dly_valid && !cap_enable) |=> (qc_valid && qc_data == '0))
        else $error("qc_data nonzero with enable off");

endmodule

bind q_control q_control_chk chk0 (
    .a_clk      (a_clk),
    .rst        (rst),
    .sample_en  (sample_en),
    .dly_valid  (dly_valid),
    .cap_enable (cap_enable),
    .qc_valid   (qc_valid),
    .qc_data    (qc_data)
);

// ==== tb/tb_q_control.sv ====
`timescale 1ns/1ns

module tb_q_control;
    import qc_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // Test table
    ////////////////////////////////////////////////////////////////////

    localparam int NROWS     = 6;
    localparam int MODE_RAMP = 0;
    localparam int MODE_RAND = 1;
    localparam int MODE_FULL = 2;

    // One row per test, applied back to back without a new reset
    string row_name  [NROWS] = '{"fill_mask", "disable", "neg_gain", "saturate",
                                 "delay_5", "delay_2"};
    logic  row_en    [NROWS] = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};
    int    row_gain  [NROWS] = '{8192, 8192, -4096, 24576, 8192, 8192};
    int    row_delay [NROWS] = '{3, 1, 17, 1, 5, 2};
    int    row_count [NROWS] = '{12, 10, 40, 12, 12, 12};
    int    row_mode  [NROWS] = '{MODE_RAMP, MODE_RAND, MODE_RAND, MODE_FULL,
                                 MODE_RAND, MODE_RAMP};

    // DUT connections
    logic    a_clk;
    logic    rst;
    sample_t signal_data;
    logic    qc_enable;
    gain_t   qc_gain;
    delay_t  qc_delay;
    sample_t qc_data;
    logic    qc_valid;

    // Reference model state
    sample_t hist [$];
    sample_t exp_q [$];
    int      row_q [$];
    int      row_errs [NROWS];
    int      row_left [NROWS];

    integer seed = 32'h1b22;
    int     errors = 0;
    int     checked = 0;
    int     pulses = 0;
    int     ticks = 0;
    bit     done = 1'b0;

    q_control dut0 (
        .a_clk       (a_clk),
        .rst         (rst),
        .signal_data (signal_data),
        .qc_enable   (qc_enable),
        .qc_gain     (qc_gain),
        .qc_delay    (qc_delay),
        .qc_data     (qc_data),
        .qc_valid    (qc_valid)
    );

    // 8 ns period
    initial
    begin
        a_clk = 1'b0;
        forever #4 a_clk = ~a_clk;
    end

    ////////////////////////////////////////////////////////////////////
    // Stimulus and expected values
    ////////////////////////////////////////////////////////////////////

    // Ramp, seeded random, or alternating full scale
    function automatic sample_t make_sample(input int mode, input int n);
        sample_t s;
        case (mode)
            MODE_RAMP: s = sample_t'(n * 311 - 1500);
            MODE_RAND: s = sample_t'($random(seed));
            default:   s = (n % 2 == 0) ? sample_t'(SAT_MAX) : sample_t'(SAT_MIN);
        endcase
        return s;
    endfunction

    // Output for sample k, k samples precede it
    function automatic sample_t expected_out(input logic en, input int gain,
                                             input int delay, input int k);
        int     span;
        longint prod;
        // Zero delay is a full ring
        span = (delay == 0) ? DEPTH : delay;
        if (!en || k < span)
        begin
            return '0;
        end
        prod = longint'(hist[k - span]) * longint'(gain);
        prod = prod >>> GAIN_Q;
        if (prod > SAT_MAX)
        begin
            return sample_t'(SAT_MAX);
        end
        if (prod < SAT_MIN)
        begin
            return sample_t'(SAT_MIN);
        end
        return sample_t'(prod);
    endfunction

    initial
    begin
        int      r;
        int      n;
        sample_t x;
        rst         = 1'b1;
        signal_data = '0;
        qc_enable   = 1'b0;
        qc_gain     = '0;
        qc_delay    = '0;
        repeat (5) @(posedge a_clk);
        rst <= 1'b0;
        @(posedge a_clk);
        for (r = 0; r < NROWS; r++)
        begin
            row_errs[r] = 0;
            row_left[r] = row_count[r];
            for (n = 0; n < row_count[r]; n++)
            begin
                // Two edges before the tick, so the input settles in between
                @(posedge a_clk);
                x = make_sample(row_mode[r], n);
                signal_data <= x;
                qc_enable   <= row_en[r];
                qc_gain     <= gain_t'(row_gain[r]);
                qc_delay    <= delay_t'(row_delay[r]);
                exp_q.push_back(expected_out(row_en[r], row_gain[r], row_delay[r],
                                             hist.size()));
                row_q.push_back(r);
                hist.push_back(x);
                ticks++;
                repeat (3) @(posedge a_clk);
            end
        end
        // Drain the pipeline, later ticks reuse held inputs and are not modeled
        while (exp_q.size() != 0)
        begin
            @(negedge a_clk);
        end
        done = 1'b1;
        if (pulses != ticks)
        begin
            errors++;
            $display("Error: saw %0d qc_valid pulses for %0d ticks issued", pulses, ticks);
        end
        $display("Done: %0d tests, %0d outputs checked, %0d errors", NROWS, checked, errors);
        if (errors == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////////////
    // Output monitor, sampled away from the rising edge
    ////////////////////////////////////////////////////////////////////

    initial
    begin
        sample_t exp_val;
        int      r;
        forever
        begin
            @(negedge a_clk);
            if (!rst && !done && qc_valid)
            begin
                pulses++;
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("Error: qc_valid pulsed with no sample pending at %0t", $time);
                end
                else
                begin
                    exp_val = exp_q.pop_front();
                    r = row_q.pop_front();
                    checked++;
                    if (qc_data !== exp_val)
                    begin
                        errors++;
                        row_errs[r]++;
                        $display("Mismatch: qc_data expected %h actual %h in test %0d",
                                 exp_val, qc_data, r);
                    end
                    row_left[r]--;
                    // Last output of the row ends the test
                    if (row_left[r] == 0)
                    begin
                        $display("Test %0d %s: %s, %0d outputs, %0d errors", r, row_name[r],
                                 (row_errs[r] == 0) ? "ok" : "failed", row_count[r],
                                 row_errs[r]);
                    end
                end
            end
        end
    end

    // Watchdog, 32 ns per sample plus margin
    initial
    begin
        int total;
        int i;
        total = 0;
        for (i = 0; i < NROWS; i++)
        begin
            total += row_count[i];
        end
        #(32 * total + 2000);
        $display("Error: timed out waiting for qc_valid, %0d outputs still pending",
                 exp_q.size());
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== flist.f ====
hw/qc_pkg.sv
hw/qc_sample_capture.sv
hw/qc_delay_line.sv
hw/qc_gain_mixer.sv
hw/q_control.sv
tb/q_control_chk.sv
tb/tb_q_control.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the Q-control testbench with Verilator.
# The run passes only if the pass message shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_q_control \
    -f flist.f \
    -o tb_q_control_sim \
    || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/tb_q_control_sim 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -q "PASS: all tests" \
    && echo "Simulation result: passed" \
    || { echo "Simulation result: failed"; exit 1; }

exit 0
